// ==== tsconf_sound.f ====
+incdir+dv
hw/zx_bus_pkg.sv
hw/audio_pkg.sv
hw/z80_bus_sync.sv
hw/port_decode.sv
hw/psg_regs.sv
hw/io_regs.sv
hw/audio_mixer.sv
hw/tsconf_sound_top.sv
dv/clk_gen.sv
dv/tb_tsconf_sound.sv

// ==== dv/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

task automatic check_val(
  input string       name,
  input logic [31:0] exp_val,
  input logic [31:0] act_val
);
  check_count++;
  if (act_val !== exp_val) begin
    error_count++;
    $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, exp_val, act_val);
  end
endtask

task automatic bus_idle;
  cpu_iorq_n = 1'b1;
  cpu_rd_n   = 1'b1;
  cpu_wr_n   = 1'b1;
  cpu_m1_n   = 1'b1;
endtask

// E0 samples the write, registers move at E2, audio at E3
task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
  @(posedge clk_28mhz);
  #2;
  cpu_a      = addr;
  cpu_do     = data;
  cpu_iorq_n = 1'b0;
  cpu_wr_n   = 1'b0;
  repeat (2) @(posedge clk_28mhz);
  #1;
  pre_border = border;
  @(posedge clk_28mhz);
  #1;
  e2_border   = border;
  e2_tape_out = tape_out;
  @(posedge clk_28mhz);
  #1;
  e3_audio_l = audio_out_l;
  e3_audio_r = audio_out_r;
  #1;
  bus_idle();
  repeat (2) @(posedge clk_28mhz);
  #2;
endtask

// read data is valid after E2 and must hold through E3
task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
  @(posedge clk_28mhz);
  #2;
  cpu_a      = addr;
  cpu_iorq_n = 1'b0;
  cpu_rd_n   = 1'b0;
  repeat (3) @(posedge clk_28mhz);
  #1;
  data = cpu_di;
  @(posedge clk_28mhz);
  #1;
  check_val("cpu_di held", data, cpu_di);
  #1;
  bus_idle();
  repeat (2) @(posedge clk_28mhz);
  #2;
endtask

task automatic wait_reset_done(output bit ok);
  int cycles;
  ok = 1'b0;
  cycles = 0;
  while (!ok && cycles < 100) begin
    @(posedge clk_28mhz);
    cycles++;
    ok = (rst === 1'b0);
  end
  if (!ok) begin
    error_count++;
    $display("reset was still high after 100 clock cycles");
  end
  #2;
endtask

`endif

// ==== dv/tb_tsconf_sound.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_tsconf_sound;

  logic        clk_28mhz;
  logic        rst;
  logic [15:0] cpu_a;
  logic [7:0]  cpu_do;
  logic        cpu_iorq_n;
  logic        cpu_rd_n;
  logic        cpu_wr_n;
  logic        cpu_m1_n;
  logic [4:0]  keyboard_data;
  logic        tape_in;
  logic        covox_en;
  logic [7:0]  cpu_di;
  logic [2:0]  border;
  logic        tape_out;
  logic [15:0] audio_out_l;
  logic [15:0] audio_out_r;

  // snapshots taken by io_write at fixed pipeline depths
  logic [2:0]  pre_border;
  logic [2:0]  e2_border;
  logic        e2_tape_out;
  logic [15:0] e3_audio_l;
  logic [15:0] e3_audio_r;

  // reference state built from the writes
  logic [7:0] fe_model;
  logic [7:0] covox_model;
  logic [7:0] psg_model [2][16];

  integer seed = 48626;
  int     error_count = 0;
  int     check_count = 0;
  bit     reset_ok;

  clk_gen i_clk_gen (
    .clk_28mhz(clk_28mhz),
    .rst      (rst)
  );

  tsconf_sound_top i_dut (.*);

  // covox byte times 64 plus fixed levels for the one-bit sources
  function automatic logic [15:0] expected_mix(
    input logic [7:0] cov,
    input logic       spk_bit,
    input logic       tout,
    input logic       tin
  );
    logic [15:0] sum;
    sum = {8'h00, cov} * 16'd64;
    if (spk_bit) sum = sum + 16'h2000;
    if (tout) sum = sum + 16'h0800;
    if (tin) sum = sum + 16'h0400;
    return sum;
  endfunction

  task automatic check_audio(input string what);
    logic [15:0] exp_mix;
    exp_mix = expected_mix(covox_model, fe_model[4], fe_model[3], tape_in);
    check_val({what, " audio_out_l"}, exp_mix, e3_audio_l);
    check_val({what, " audio_out_r"}, exp_mix, e3_audio_r);
  endtask

  task automatic test_reset;
    check_val("cpu_di", 8'hFF, cpu_di);
    check_val("border", 0, border);
    check_val("tape_out", 0, tape_out);
    check_val("audio_out_l", 0, audio_out_l);
    check_val("audio_out_r", 0, audio_out_r);
  endtask

  task automatic test_fe_port;
    logic [7:0] data;
    logic [7:0] rdata;
    for (int i = 0; i < 8; i++) begin
      data = $random(seed);
      io_write(16'h00FE, data);
      check_val("border before E2", fe_model[2:0], pre_border);
      fe_model = data;
      check_val("border", data[2:0], e2_border);
      check_val("tape_out", data[3], e2_tape_out);
      keyboard_data = $random(seed);
      tape_in = $random(seed);
      io_read(16'h00FE, rdata);
      check_val("cpu_di #FE", {1'b1, tape_in, 1'b1, keyboard_data}, rdata);
    end
  endtask

  task automatic test_turbosound;
    logic [3:0] idx [4];
    logic [7:0] rdata;
    for (int i = 0; i < 4; i++) begin
      idx[i] = $random(seed);
    end
    for (int c = 0; c < 2; c++) begin
      io_write(16'hFFFD, (c == 0) ? 8'hFF : 8'hFE);
      for (int i = 0; i < 4; i++) begin
        io_write(16'hFFFD, {4'h0, idx[i]});
        // chip 1 gets the inverse so the two files always differ
        psg_model[c][idx[i]] = (c == 0) ? 8'($random(seed)) : ~psg_model[0][idx[i]];
        io_write(16'hBFFD, psg_model[c][idx[i]]);
      end
    end
    for (int c = 0; c < 2; c++) begin
      io_write(16'hFFFD, (c == 0) ? 8'hFF : 8'hFE);
      for (int i = 0; i < 4; i++) begin
        io_write(16'hFFFD, {4'h0, idx[i]});
        io_read(16'hFFFD, rdata);
        check_val("cpu_di psg", psg_model[c][idx[i]], rdata);
      end
    end
  endtask

  task automatic test_covox;
    logic [7:0] data;
    covox_en = 1'b0;
    io_write(16'h00FB, 8'($random(seed)));
    check_audio("covox off");
    covox_en = 1'b1;
    data = $random(seed);
    io_write(16'h00FB, data);
    covox_model = data;
    check_audio("covox on");
  endtask

  task automatic test_mixer;
    logic [7:0] cov;
    covox_en = 1'b1;
    for (int combo = 0; combo < 8; combo++) begin
      tape_in = combo[2];
      fe_model = $random(seed);
      fe_model[4] = combo[0];
      fe_model[3] = combo[1];
      io_write(16'h00FE, fe_model);
      cov = $random(seed);
      io_write(16'h00FB, cov);
      covox_model = cov;
      check_audio("mix");
    end
  endtask

  task automatic test_unused_port;
    logic [7:0] rdata;
    io_read(16'h001F, rdata);
    check_val("cpu_di #1F", 8'hFF, rdata);
    io_write(16'h001F, 8'($random(seed)));
    check_val("border", fe_model[2:0], border);
    check_val("tape_out", fe_model[3], tape_out);
    check_audio("#1F write");
    check_val("cpu_di idle", 8'hFF, cpu_di);
  endtask

  initial begin
    cpu_a         = '0;
    cpu_do        = '0;
    keyboard_data = '0;
    tape_in       = 1'b0;
    covox_en      = 1'b0;
    fe_model      = '0;
    covox_model   = '0;
    bus_idle();
    wait_reset_done(reset_ok);
    if (reset_ok) begin
      test_reset();
      test_fe_port();
      test_turbosound();
      test_covox();
      test_mixer();
      test_unused_port();
    end
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

`include "tb_bus_tasks.svh"

endmodule

`default_nettype wire

// ==== dv/clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
  output logic clk_28mhz,
  output logic rst
);

  // 40 ns period
  initial begin
    clk_28mhz = 1'b0;
    forever #20 clk_28mhz = ~clk_28mhz;
  end

  // reset held over three rising edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk_28mhz);
    #2;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== hw/tsconf_sound_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tsconf_sound_top
  import zx_bus_pkg::*;
  import audio_pkg::*;
(
  input  logic                clk_28mhz,
  input  logic                rst,
  input  logic [ADDR_W-1:0]   cpu_a,
  input  logic [DATA_W-1:0]   cpu_do,
  input  logic                cpu_iorq_n,
  input  logic                cpu_rd_n,
  input  logic                cpu_wr_n,
  input  logic                cpu_m1_n,
  input  logic [KEY_W-1:0]    keyboard_data,
  input  logic                tape_in,
  input  logic                covox_en,
  output logic [DATA_W-1:0]   cpu_di,
  output logic [BORDER_W-1:0] border,
  output logic                tape_out,
  output logic [AUDIO_W-1:0]  audio_out_l,
  output logic [AUDIO_W-1:0]  audio_out_r
);

  // bus sync stage
  logic [ADDR_W-1:0] bus_a;
  logic [DATA_W-1:0] bus_d;
  logic              io_wr_stb;
  logic              io_rd;

  // decode stage
  logic [DATA_W-1:0] wr_data;
  logic              fe_wr;
  logic              psg_addr_wr;
  logic              psg_data_wr;
  logic              covox_wr;
  logic              fe_rd;
  logic              psg_rd;

  // register stage
  logic [DATA_W-1:0] psg_rdata;
  logic [DATA_W-1:0] covox_val;
  logic              spk;

  z80_bus_sync i_bus_sync (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .cpu_a     (cpu_a),
    .cpu_do    (cpu_do),
    .cpu_iorq_n(cpu_iorq_n),
    .cpu_rd_n  (cpu_rd_n),
    .cpu_wr_n  (cpu_wr_n),
    .cpu_m1_n  (cpu_m1_n),
    .bus_a     (bus_a),
    .bus_d     (bus_d),
    .io_wr_stb (io_wr_stb),
    .io_rd     (io_rd)
  );

  port_decode i_port_decode (
    .clk_28mhz  (clk_28mhz),
    .rst        (rst),
    .bus_a      (bus_a),
    .bus_d      (bus_d),
    .io_wr_stb  (io_wr_stb),
    .io_rd      (io_rd),
    .covox_en   (covox_en),
    .wr_data    (wr_data),
    .fe_wr      (fe_wr),
    .psg_addr_wr(psg_addr_wr),
    .psg_data_wr(psg_data_wr),
    .covox_wr   (covox_wr),
    .fe_rd      (fe_rd),
    .psg_rd     (psg_rd)
  );

  psg_regs i_psg_regs (
    .clk_28mhz  (clk_28mhz),
    .rst        (rst),
    .wr_data    (wr_data),
    .psg_addr_wr(psg_addr_wr),
    .psg_data_wr(psg_data_wr),
    .psg_rdata  (psg_rdata)
  );

  io_regs i_io_regs (
    .clk_28mhz    (clk_28mhz),
    .rst          (rst),
    .wr_data      (wr_data),
    .fe_wr        (fe_wr),
    .covox_wr     (covox_wr),
    .fe_rd        (fe_rd),
    .psg_rd       (psg_rd),
    .psg_rdata    (psg_rdata),
    .keyboard_data(keyboard_data),
    .tape_in      (tape_in),
    .cpu_di       (cpu_di),
    .border       (border),
    .tape_out     (tape_out),
    .spk          (spk),
    .covox_val    (covox_val)
  );

  audio_mixer i_audio_mixer (
    .clk_28mhz  (clk_28mhz),
    .rst        (rst),
    .covox_val  (covox_val),
    .spk        (spk),
    .tape_out   (tape_out),
    .tape_in    (tape_in),
    .audio_out_l(audio_out_l),
    .audio_out_r(audio_out_r)
  );

endmodule

`default_nettype wire

// ==== hw/audio_mixer.sv ====
`timescale 1ns/10ps
`default_nettype none

module audio_mixer
  import zx_bus_pkg::*;
  import audio_pkg::*;
(
  input  logic               clk_28mhz,
  input  logic               rst,
  input  logic [DATA_W-1:0]  covox_val,
  input  logic               spk,
  input  logic               tape_out,
  input  logic               tape_in,
  output logic [AUDIO_W-1:0] audio_out_l,
  output logic [AUDIO_W-1:0] audio_out_r
);

  logic [AUDIO_W-1:0] covox_term;
  logic [AUDIO_W-1:0] mix_sum;

  // dac byte scaled into the upper part of the range
  assign covox_term = AUDIO_W'(covox_val) << COVOX_SHIFT;

  // one-bit sources add fixed levels
  always_comb begin
    mix_sum = covox_term;
    if (spk) begin
      mix_sum = mix_sum + SPK_LEVEL;
    end
    if (tape_out) begin
      mix_sum = mix_sum + TAPE_OUT_LEVEL;
    end
    if (tape_in) begin
      mix_sum = mix_sum + TAPE_IN_LEVEL;
    end
  end

  // same mono sum on both channels
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      audio_out_l <= '0;
      audio_out_r <= '0;
    end else begin
      audio_out_l <= mix_sum;
      audio_out_r <= mix_sum;
    end
  end

endmodule

`default_nettype wire

// ==== hw/io_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module io_regs
  import zx_bus_pkg::*;
(
  input  logic                clk_28mhz,
  input  logic                rst,
  input  logic [DATA_W-1:0]   wr_data,
  input  logic                fe_wr,
  input  logic                covox_wr,
  input  logic                fe_rd,
  input  logic                psg_rd,
  input  logic [DATA_W-1:0]   psg_rdata,
  input  logic [KEY_W-1:0]    keyboard_data,
  input  logic                tape_in,
  output logic [DATA_W-1:0]   cpu_di,
  output logic [BORDER_W-1:0] border,
  output logic                tape_out,
  output logic                spk,
  output logic [DATA_W-1:0]   covox_val
);

  logic [DATA_W-1:0] fe_rd_byte;

  // unused bits of the #FE read byte are high
  always_comb begin
    fe_rd_byte = '1;
    fe_rd_byte[KEY_W-1:0] = keyboard_data;
    fe_rd_byte[FE_TAPE_IN_BIT] = tape_in;
  end

  // #FE fields
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      border   <= '0;
      tape_out <= 1'b0;
      spk      <= 1'b0;
    end else if (fe_wr) begin
      border   <= wr_data[BORDER_W-1:0];
      tape_out <= wr_data[FE_TAPE_OUT_BIT];
      spk      <= wr_data[FE_SPK_BIT];
    end
  end

  // covox dac byte
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      covox_val <= '0;
    end else if (covox_wr) begin
      covox_val <= wr_data;
    end
  end

  // idle bus reads as FF
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      cpu_di <= '1;
    end else if (fe_rd) begin
      cpu_di <= fe_rd_byte;
    end else if (psg_rd) begin
      cpu_di <= psg_rdata;
    end else begin
      cpu_di <= '1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/psg_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module psg_regs
  import zx_bus_pkg::*;
(
  input  logic              clk_28mhz,
  input  logic              rst,
  input  logic [DATA_W-1:0] wr_data,
  input  logic              psg_addr_wr,
  input  logic              psg_data_wr,
  output logic [DATA_W-1:0] psg_rdata
);

  // 0 for chip 0, 1 for chip 1
  logic                 chip_sel;
  logic [PSG_IDX_W-1:0] psg_idx;

  // one register file per chip
  logic [DATA_W-1:0] psg_file [2][PSG_REG_NUM];

  logic is_chip0_code;
  logic is_chip1_code;

  assign is_chip0_code = wr_data == TS_CHIP0_CODE;
  assign is_chip1_code = wr_data == TS_CHIP1_CODE;

  // select write carries a chip code or a register index
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      chip_sel <= 1'b0;
      psg_idx  <= '0;
    end else if (psg_addr_wr) begin
      if (is_chip0_code) begin
        chip_sel <= 1'b0;
      end else if (is_chip1_code) begin
        chip_sel <= 1'b1;
      end else begin
        psg_idx <= wr_data[PSG_IDX_W-1:0];
      end
    end
  end

  // data write into the indexed register of the selected chip
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      for (int c = 0; c < 2; c++) begin
        for (int r = 0; r < PSG_REG_NUM; r++) begin
          psg_file[c][r] <= '0;
        end
      end
    end else if (psg_data_wr) begin
      psg_file[chip_sel][psg_idx] <= wr_data;
    end
  end

  // read path always shows the current register
  assign psg_rdata = psg_file[chip_sel][psg_idx];

  // chip codes and index values are disjoint
  a_sel_exclusive: assert property (
    @(posedge clk_28mhz) disable iff (rst)
    psg_addr_wr |=> !($changed(chip_sel) && $changed(psg_idx))
  );

endmodule

`default_nettype wire

// ==== hw/port_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module port_decode
  import zx_bus_pkg::*;
(
  input  logic              clk_28mhz,
  input  logic              rst,
  input  logic [ADDR_W-1:0] bus_a,
  input  logic [DATA_W-1:0] bus_d,
  input  logic              io_wr_stb,
  input  logic              io_rd,
  input  logic              covox_en,
  output logic [DATA_W-1:0] wr_data,
  output logic              fe_wr,
  output logic              psg_addr_wr,
  output logic              psg_data_wr,
  output logic              covox_wr,
  output logic              fe_rd,
  output logic              psg_rd
);

  logic fe_hit;
  logic fb_hit;
  logic fd_hit;
  logic psg_addr_hit;
  logic psg_data_hit;

  // low byte match
  assign fe_hit = bus_a[7:0] == PORT_FE;
  assign fb_hit = bus_a[7:0] == PORT_FB;
  assign fd_hit = bus_a[7:0] == PORT_FD;

  // #FFFD selects, #BFFD carries data
  assign psg_addr_hit = fd_hit && bus_a[PSG_HI_BIT] && bus_a[PSG_SEL_BIT];
  assign psg_data_hit = fd_hit && bus_a[PSG_HI_BIT] && !bus_a[PSG_SEL_BIT];

  // data byte travels alongside the strobes
  always_ff @(posedge clk_28mhz) begin
    wr_data <= bus_d;
  end

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      fe_wr       <= 1'b0;
      psg_addr_wr <= 1'b0;
      psg_data_wr <= 1'b0;
      covox_wr    <= 1'b0;
      fe_rd       <= 1'b0;
      psg_rd      <= 1'b0;
    end else begin
      fe_wr       <= io_wr_stb && fe_hit;
      psg_addr_wr <= io_wr_stb && psg_addr_hit;
      psg_data_wr <= io_wr_stb && psg_data_hit;
      // dac port only exists while enabled
      covox_wr    <= io_wr_stb && fb_hit && covox_en;
      fe_rd       <= io_rd && fe_hit;
      psg_rd      <= io_rd && psg_addr_hit;
    end
  end

  // write strobes never overlap, so downstream registers need no priority
  a_wr_onehot: assert property (
    @(posedge clk_28mhz) disable iff (rst)
    $onehot0({fe_wr, psg_addr_wr, psg_data_wr, covox_wr})
  );

endmodule

`default_nettype wire

// ==== hw/z80_bus_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module z80_bus_sync
  import zx_bus_pkg::*;
(
  input  logic              clk_28mhz,
  input  logic              rst,
  input  logic [ADDR_W-1:0] cpu_a,
  input  logic [DATA_W-1:0] cpu_do,
  input  logic              cpu_iorq_n,
  input  logic              cpu_rd_n,
  input  logic              cpu_wr_n,
  input  logic              cpu_m1_n,
  output logic [ADDR_W-1:0] bus_a,
  output logic [DATA_W-1:0] bus_d,
  output logic              io_wr_stb,
  output logic              io_rd
);

  logic wr_now;
  logic rd_now;
  logic wr_prev;

  // interrupt acknowledge has iorq with m1, so m1 must be inactive
  assign wr_now = !cpu_iorq_n && !cpu_wr_n && cpu_m1_n;
  assign rd_now = !cpu_iorq_n && !cpu_rd_n && cpu_m1_n;

  // address and data follow the bus every cycle
  always_ff @(posedge clk_28mhz) begin
    bus_a <= cpu_a;
    bus_d <= cpu_do;
  end

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      wr_prev   <= 1'b0;
      io_wr_stb <= 1'b0;
      io_rd     <= 1'b0;
    end else begin
      wr_prev <= wr_now;
      // first sampled cycle of a write only
      io_wr_stb <= wr_now && !wr_prev;
      io_rd     <= rd_now;
    end
  end

  // a held write still yields a single strobe
  a_wr_stb_single: assert property (
    @(posedge clk_28mhz) disable iff (rst)
    io_wr_stb |=> !io_wr_stb
  );

endmodule

`default_nettype wire

// ==== hw/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

  // width of each output channel
  localparam int AUDIO_W = 16;

  // covox byte lands in bits 13:6
  localparam int COVOX_SHIFT = 6;

  // fixed contributions of the one-bit sources
  localparam logic [AUDIO_W-1:0] SPK_LEVEL      = 16'h2000;
  localparam logic [AUDIO_W-1:0] TAPE_OUT_LEVEL = 16'h0800;
  localparam logic [AUDIO_W-1:0] TAPE_IN_LEVEL  = 16'h0400;

  // full scale sum is 27584, so no overflow in 16 bits

endpackage

`default_nettype wire

// ==== hw/zx_bus_pkg.sv ====
`default_nettype none

package zx_bus_pkg;

  // cpu bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  // low address byte of each port
  localparam logic [7:0] PORT_FE = 8'hFE;
  localparam logic [7:0] PORT_FB = 8'hFB;
  localparam logic [7:0] PORT_FD = 8'hFD;

  // A15 high on both psg ports, A14 splits #FFFD from #BFFD
  localparam int PSG_SEL_BIT = 14;
  localparam int PSG_HI_BIT  = 15;

  // turbosound register files
  localparam int PSG_REG_NUM = 16;
  localparam int PSG_IDX_W   = 4;
  localparam logic [DATA_W-1:0] TS_CHIP0_CODE = 8'hFF;
  localparam logic [DATA_W-1:0] TS_CHIP1_CODE = 8'hFE;

  // #FE fields
  localparam int FE_TAPE_OUT_BIT = 3;
  localparam int FE_SPK_BIT      = 4;
  localparam int BORDER_W        = 3;
  localparam int KEY_W           = 5;
  localparam int FE_TAPE_IN_BIT  = 6;

endpackage

`default_nettype wire
